//--- scope_pkg.sv
package scope_pkg;

   // channel and sample geometry
   localparam int NUM_CHAN   = 2;
   localparam int SAMPLE_W   = 10;
   localparam int unsigned SAMPLE_MAX = 1023;    // full-scale adc code
   localparam int GAIN_W     = 8;
   localparam int GAIN_SHIFT = 4;                // 4 fractional bits, 16 is unity

   localparam int DECIM_W   = 16;
   localparam int OFFSET_W  = 32;
   localparam int COUNT_W   = 32;
   localparam int BYTECNT_W = 7;
   localparam int CHAN_ID_W = 1;

   localparam logic [7:0] ADDR_GAIN        = 8'd0;
   localparam logic [7:0] ADDR_SETTINGS    = 8'd1;
   localparam logic [7:0] ADDR_STATUS      = 8'd2;
   localparam logic [7:0] ADDR_ECHO        = 8'd4;   // 8 bytes
   localparam logic [7:0] ADDR_VERSION     = 8'd5;   // 2 bytes
   localparam logic [7:0] ADDR_DECIMATE    = 8'd6;   // 2 bytes
   localparam logic [7:0] ADDR_SAMPLES     = 8'd7;   // 4 bytes
   localparam logic [7:0] ADDR_OFFSET      = 8'd8;   // 4 bytes
   localparam logic [7:0] ADDR_TRIG_LEVEL  = 8'd9;   // 2 bytes
   localparam logic [7:0] ADDR_TRIG_CHAN   = 8'd10;
   localparam logic [7:0] ADDR_MAX_SAMPLES = 8'd11;  // 4 bytes
   localparam logic [7:0] ADDR_TRIG_DUR    = 8'd12;  // 4 bytes
   localparam logic [7:0] ADDR_NO_CLIP     = 8'd13;

   localparam int BIT_SOFT_RESET  = 0;
   localparam int BIT_TRIG_RISING = 2;
   localparam int BIT_ARM         = 3;
   localparam int BIT_TRIG_NOW    = 6;
   localparam logic [7:0] SETTINGS_RESET_VAL = 8'(1 << BIT_TRIG_RISING);

   localparam int BIT_ARMED     = 0;
   localparam int BIT_TRIGGERED = 1;
   localparam int BIT_DONE      = 2;
   localparam int BIT_OVERFLOW  = 3;
   localparam int BIT_CLIP0     = 4;                 // one bit per channel upward

   // hw type, hw version, spare nibble, register version
   localparam logic [15:0] VERSION_CODE = {5'd3, 3'd1, 4'd0, 4'd2};

   localparam logic [COUNT_W-1:0] MAX_SAMPLES       = 32'd8192;
   localparam logic [COUNT_W-1:0] SAMPLES_RESET_VAL = 32'd16;

endpackage

//--- scope_cfg_if.sv
`timescale 1ns/1ps

interface scope_cfg_if
   import scope_pkg::*;
();

   logic                 cap_reset;      // soft reset of capture path only
   logic [GAIN_W-1:0]    gain;
   logic [SAMPLE_W-1:0]  trig_level;
   logic                 trig_rising;
   logic [CHAN_ID_W-1:0] trig_chan;
   logic                 arm;
   logic                 trig_now;
   logic [OFFSET_W-1:0]  offset;
   logic [COUNT_W-1:0]   samples;
   logic [DECIM_W-1:0]   decimate;
   logic                 no_clip;

   logic                 strobe;         // aligned with registered channel samples
   logic                 window_closed;
   logic                 armed;
   logic                 triggered;
   logic [COUNT_W-1:0]   trig_dur;

   logic                 overflow;
   logic                 done;

   modport regs (
      output cap_reset, gain, trig_level, trig_rising, trig_chan, arm, trig_now,
      output offset, samples, decimate, no_clip,
      input  armed, triggered, trig_dur, overflow, done
   );

   modport sequencer (
      input  cap_reset, trig_chan, arm, trig_now, offset, samples, decimate,
      output strobe, window_closed, armed, triggered, trig_dur
   );

   modport merger (
      input  cap_reset, strobe, window_closed,
      output overflow, done
   );

endinterface

//--- scope_regs.sv
`timescale 1ns/1ps

module scope_regs
   import scope_pkg::*;
(
   input  logic                 clk_usb,
   input  logic                 reset,
   input  logic [7:0]           reg_address_i,
   input  logic [BYTECNT_W-1:0] reg_bytecnt_i,   // byte lane within register
   input  logic [7:0]           reg_datai_i,
   input  logic                 reg_write_i,
   input  logic                 reg_read_i,
   output logic [7:0]           reg_datao_o,
   input  logic                 clip_i [NUM_CHAN],
   scope_cfg_if.regs            cfg
);

   logic [GAIN_W-1:0]    reg_gain;
   logic [7:0]           reg_settings;
   logic [63:0]          reg_echo;
   logic [DECIM_W-1:0]   reg_decimate;
   logic [COUNT_W-1:0]   reg_samples;
   logic [OFFSET_W-1:0]  reg_offset;
   logic [15:0]          reg_trig_level;
   logic [CHAN_ID_W-1:0] reg_trig_chan;
   logic                 reg_no_clip;
   logic [NUM_CHAN-1:0]  clip_sticky;
   logic [COUNT_W-1:0]   samples_wr;
   logic [7:0]           status;

   assign cfg.cap_reset   = reg_settings[BIT_SOFT_RESET];
   assign cfg.gain        = reg_gain;
   assign cfg.trig_level  = reg_trig_level[SAMPLE_W-1:0];
   assign cfg.trig_rising = reg_settings[BIT_TRIG_RISING];
   assign cfg.trig_chan   = reg_trig_chan;
   assign cfg.arm         = reg_settings[BIT_ARM];
   assign cfg.trig_now    = reg_settings[BIT_TRIG_NOW];
   assign cfg.offset      = reg_offset;
   assign cfg.samples     = reg_samples;
   assign cfg.decimate    = reg_decimate;
   assign cfg.no_clip     = reg_no_clip;

   // sample count as it would look after this byte lands
   always_comb begin
      samples_wr = reg_samples;
      samples_wr[reg_bytecnt_i*8 +: 8] = reg_datai_i;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         reg_gain       <= '0;
         reg_settings   <= SETTINGS_RESET_VAL;
         reg_echo       <= '0;
         reg_decimate   <= '0;
         reg_samples    <= SAMPLES_RESET_VAL;
         reg_offset     <= '0;
         reg_trig_level <= '0;
         reg_trig_chan  <= '0;
         reg_no_clip    <= 1'b0;
      end else begin
         if (reg_settings[BIT_SOFT_RESET])
            reg_settings[BIT_SOFT_RESET] <= 1'b0;   // self-clearing pulse
         if (reg_write_i) begin
            case (reg_address_i)
               ADDR_GAIN:       reg_gain <= reg_datai_i;
               ADDR_SETTINGS:   reg_settings <= reg_datai_i;
               ADDR_ECHO:       reg_echo[reg_bytecnt_i*8 +: 8] <= reg_datai_i;
               ADDR_DECIMATE:   reg_decimate[reg_bytecnt_i*8 +: 8] <= reg_datai_i;
               ADDR_SAMPLES:    reg_samples <= (samples_wr > MAX_SAMPLES) ? MAX_SAMPLES
                                                                          : samples_wr;
               ADDR_OFFSET:     reg_offset[reg_bytecnt_i*8 +: 8] <= reg_datai_i;
               ADDR_TRIG_LEVEL: reg_trig_level[reg_bytecnt_i*8 +: 8] <= reg_datai_i;
               ADDR_TRIG_CHAN:  reg_trig_chan <= reg_datai_i[CHAN_ID_W-1:0];
               ADDR_NO_CLIP:    reg_no_clip <= reg_datai_i[0];
               default: ;                               // read-only or unmapped
            endcase
         end
      end
   end

   // clip history, held until soft reset
   always_ff @(posedge clk_usb) begin
      if (reset || reg_settings[BIT_SOFT_RESET]) begin
         clip_sticky <= '0;
      end else begin
         for (int c = 0; c < NUM_CHAN; c++) begin
            if (clip_i[c] && !cfg.no_clip)
               clip_sticky[c] <= 1'b1;
         end
      end
   end

   always_comb begin
      status                = '0;
      status[BIT_ARMED]     = cfg.armed;
      status[BIT_TRIGGERED] = cfg.triggered;
      status[BIT_DONE]      = cfg.done;
      status[BIT_OVERFLOW]  = cfg.overflow;
      for (int c = 0; c < NUM_CHAN; c++)
         status[BIT_CLIP0 + c] = clip_sticky[c];
   end

   always_comb begin
      reg_datao_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            ADDR_GAIN:        reg_datao_o = reg_gain;
            ADDR_SETTINGS:    reg_datao_o = reg_settings;
            ADDR_STATUS:      reg_datao_o = status;
            ADDR_ECHO:        reg_datao_o = reg_echo[reg_bytecnt_i*8 +: 8];
            ADDR_VERSION:     reg_datao_o = VERSION_CODE[reg_bytecnt_i*8 +: 8];
            ADDR_DECIMATE:    reg_datao_o = reg_decimate[reg_bytecnt_i*8 +: 8];
            ADDR_SAMPLES:     reg_datao_o = reg_samples[reg_bytecnt_i*8 +: 8];
            ADDR_OFFSET:      reg_datao_o = reg_offset[reg_bytecnt_i*8 +: 8];
            ADDR_TRIG_LEVEL:  reg_datao_o = reg_trig_level[reg_bytecnt_i*8 +: 8];
            ADDR_TRIG_CHAN:   reg_datao_o = 8'(reg_trig_chan);
            ADDR_MAX_SAMPLES: reg_datao_o = MAX_SAMPLES[reg_bytecnt_i*8 +: 8];
            ADDR_TRIG_DUR:    reg_datao_o = cfg.trig_dur[reg_bytecnt_i*8 +: 8];
            ADDR_NO_CLIP:     reg_datao_o = {7'b0, reg_no_clip};
            default:          reg_datao_o = '0;
         endcase
      end
   end

   a_samples_in_range: assert property (@(posedge clk_usb) disable iff (reset)
      reg_write_i && (reg_address_i == ADDR_SAMPLES) |=> reg_samples <= MAX_SAMPLES);

endmodule

//--- capture_sequencer.sv
`timescale 1ns/1ps

module capture_sequencer
   import scope_pkg::*;
(
   input  logic           clk_usb,
   input  logic           reset,
   input  logic           adc_valid_i,
   input  logic           cross_i [NUM_CHAN],   // registered crossing pulses
   scope_cfg_if.sequencer cfg
);

   typedef enum logic [2:0] {ST_IDLE, ST_ARMED, ST_SKIP, ST_CAPTURE, ST_DONE} state_t;

   state_t              state;
   state_t              cur_state;     // state seen by this cycle's valid
   logic                arm_q;
   logic                trig_hit;
   logic                take;
   logic                last;
   logic [OFFSET_W-1:0] skip_cnt;
   logic [DECIM_W-1:0]  phase;
   logic [COUNT_W-1:0]  strobe_cnt;

   always_comb begin
      trig_hit  = (state == ST_ARMED) && (cross_i[cfg.trig_chan] || cfg.trig_now);
      cur_state = state;
      if (trig_hit)
         cur_state = (cfg.offset == '0) ? ST_CAPTURE : ST_SKIP;
      take = (phase == '0) && (strobe_cnt < cfg.samples);
      last = (phase == cfg.decimate) && (strobe_cnt + COUNT_W'(take) >= cfg.samples);
   end

   assign cfg.armed         = (state == ST_ARMED);
   assign cfg.triggered     = (state == ST_SKIP) || (state == ST_CAPTURE) || (state == ST_DONE);
   assign cfg.window_closed = (state == ST_DONE);

   always_ff @(posedge clk_usb) begin
      if (reset || cfg.cap_reset) begin
         state        <= ST_IDLE;
         arm_q        <= 1'b0;
         skip_cnt     <= '0;
         phase        <= '0;
         strobe_cnt   <= '0;
         cfg.strobe   <= 1'b0;
         cfg.trig_dur <= '0;
      end else begin
         arm_q      <= cfg.arm;
         cfg.strobe <= 1'b0;
         if (cfg.arm && !arm_q) begin                 // arm edge restarts capture
            state        <= ST_ARMED;
            skip_cnt     <= '0;
            phase        <= '0;
            strobe_cnt   <= '0;
            cfg.trig_dur <= '0;
         end else begin
            state <= cur_state;
            if (adc_valid_i && (cur_state == ST_SKIP)) begin
               cfg.trig_dur <= cfg.trig_dur + 1'b1;
               skip_cnt     <= skip_cnt + 1'b1;
               if (skip_cnt == cfg.offset - 1'b1)
                  state <= ST_CAPTURE;
            end
            if (adc_valid_i && (cur_state == ST_CAPTURE)) begin
               cfg.trig_dur <= cfg.trig_dur + 1'b1;
               cfg.strobe   <= take;
               strobe_cnt   <= strobe_cnt + COUNT_W'(take);
               phase        <= (phase == cfg.decimate) ? '0 : phase + 1'b1;
               if (last)
                  state <= ST_DONE;                    // full decimation period done
            end
         end
      end
   end

   // the last strobe of a window lands as the state reaches done
   a_strobe_in_window: assert property (@(posedge clk_usb) disable iff (reset || cfg.cap_reset)
      cfg.strobe |-> (state == ST_CAPTURE) || (state == ST_DONE));

endmodule

//--- chan_condition.sv
`timescale 1ns/1ps

module chan_condition
   import scope_pkg::*;
(
   input  logic                clk_usb,
   input  logic                reset,
   input  logic                adc_valid_i,
   input  logic [SAMPLE_W-1:0] sample_i,
   output logic [SAMPLE_W-1:0] sample_o,
   output logic                clip_o,
   output logic                cross_o,
   scope_cfg_if                cfg          // reads gain and trigger setup only
);

   logic [SAMPLE_W+GAIN_W-1:0] product;
   logic [SAMPLE_W+GAIN_W-1:0] scaled;
   logic                       sat_hit;
   logic [SAMPLE_W-1:0]        sat;
   logic                       raw_rail;
   logic                       crossed;
   logic                       have_prev;   // sample_o holds a real previous value

   always_comb begin
      product  = sample_i * cfg.gain;
      scaled   = product >> GAIN_SHIFT;
      sat_hit  = scaled > SAMPLE_MAX;
      sat      = sat_hit ? SAMPLE_W'(SAMPLE_MAX) : scaled[SAMPLE_W-1:0];
      raw_rail = (sample_i == '0) || (sample_i == SAMPLE_W'(SAMPLE_MAX));
      if (cfg.trig_rising)
         crossed = (sat >= cfg.trig_level) && (sample_o < cfg.trig_level);
      else
         crossed = (sat <= cfg.trig_level) && (sample_o > cfg.trig_level);
   end

   always_ff @(posedge clk_usb) begin
      if (reset || cfg.cap_reset) begin
         clip_o    <= 1'b0;
         cross_o   <= 1'b0;
         have_prev <= 1'b0;
      end else begin
         clip_o  <= adc_valid_i && (sat_hit || raw_rail);
         cross_o <= adc_valid_i && have_prev && crossed;
         if (adc_valid_i)
            have_prev <= 1'b1;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (adc_valid_i)
         sample_o <= sat;
   end

endmodule

//--- stream_merge.sv
`timescale 1ns/1ps

module stream_merge
   import scope_pkg::*;
(
   input  logic                 clk_usb,
   input  logic                 reset,
   input  logic [SAMPLE_W-1:0]  sample_i [NUM_CHAN],
   output logic                 stream_valid_o,
   input  logic                 stream_ready_i,
   output logic [SAMPLE_W-1:0]  stream_data_o,
   output logic [CHAN_ID_W-1:0] stream_chan_o,
   scope_cfg_if.merger          cfg
);

   logic [SAMPLE_W-1:0]  hold [NUM_CHAN];
   logic [NUM_CHAN-1:0]  full;
   logic [NUM_CHAN-1:0]  taken;      // word leaving this cycle
   logic                 can_load;   // every hold empty after this cycle
   logic [CHAN_ID_W-1:0] sel;

   // lowest full channel goes first
   always_comb begin
      sel = '0;
      for (int c = NUM_CHAN - 1; c >= 0; c--) begin
         if (full[c])
            sel = CHAN_ID_W'(c);
      end
      taken = '0;
      if (stream_valid_o && stream_ready_i)
         taken[sel] = 1'b1;
   end

   assign stream_valid_o = |full;
   assign stream_data_o  = hold[sel];
   assign stream_chan_o  = sel;
   assign can_load       = !(|(full & ~taken));
   assign cfg.done       = cfg.window_closed && !cfg.strobe && !(|full);

   always_ff @(posedge clk_usb) begin
      if (reset || cfg.cap_reset) begin
         full         <= '0;
         cfg.overflow <= 1'b0;
      end else begin
         full <= full & ~taken;
         if (cfg.strobe) begin
            if (!can_load)
               cfg.overflow <= 1'b1;        // words of this strobe are lost
            else
               full <= '1;
         end
      end
   end

   always_ff @(posedge clk_usb) begin
      if (cfg.strobe && can_load)
         hold <= sample_i;
   end

   a_hold_stable: assert property (@(posedge clk_usb) disable iff (reset || cfg.cap_reset)
      stream_valid_o && !stream_ready_i |=>
         stream_valid_o && $stable(stream_data_o) && $stable(stream_chan_o));

endmodule

//--- scope_capture_top.sv
`timescale 1ns/1ps

module scope_capture_top
   import scope_pkg::*;
(
   input  logic                 clk_usb,
   input  logic                 reset,
   input  logic [7:0]           reg_address_i,
   input  logic [BYTECNT_W-1:0] reg_bytecnt_i,
   input  logic [7:0]           reg_datai_i,
   input  logic                 reg_write_i,
   input  logic                 reg_read_i,
   output logic [7:0]           reg_datao_o,
   input  logic                 adc_valid_i,
   input  logic [SAMPLE_W-1:0]  adc_sample_i [NUM_CHAN],
   output logic                 stream_valid_o,
   input  logic                 stream_ready_i,
   output logic [SAMPLE_W-1:0]  stream_data_o,
   output logic [CHAN_ID_W-1:0] stream_chan_o
);

   scope_cfg_if cfg ();

   logic [SAMPLE_W-1:0] chan_sample [NUM_CHAN];   // scaled and saturated
   logic                chan_clip   [NUM_CHAN];
   logic                chan_cross  [NUM_CHAN];

   scope_regs i_regs (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_address_i (reg_address_i),
      .reg_bytecnt_i (reg_bytecnt_i),
      .reg_datai_i   (reg_datai_i),
      .reg_write_i   (reg_write_i),
      .reg_read_i    (reg_read_i),
      .reg_datao_o   (reg_datao_o),
      .clip_i        (chan_clip),
      .cfg           (cfg)
   );

   capture_sequencer i_seq (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .adc_valid_i (adc_valid_i),
      .cross_i     (chan_cross),
      .cfg         (cfg)
   );

   for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
      chan_condition i_chan (
         .clk_usb     (clk_usb),
         .reset       (reset),
         .adc_valid_i (adc_valid_i),
         .sample_i    (adc_sample_i[c]),
         .sample_o    (chan_sample[c]),
         .clip_o      (chan_clip[c]),
         .cross_o     (chan_cross[c]),
         .cfg         (cfg)
      );
   end

   stream_merge i_merge (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .sample_i       (chan_sample),
      .stream_valid_o (stream_valid_o),
      .stream_ready_i (stream_ready_i),
      .stream_data_o  (stream_data_o),
      .stream_chan_o  (stream_chan_o),
      .cfg            (cfg)
   );

endmodule

//--- tb_scope_capture.sv
`timescale 1ns/1ps

module tb_scope_capture;
   import scope_pkg::*;

   localparam int CLK_PERIOD      = 4;
   localparam int TRIG_LEVEL      = 512;
   localparam int TOTAL_SAMPLES   = 15 + 2 * 16 + 2 * 2 + 2;   // samples driven over all tests
   localparam int WATCHDOG_CYCLES = 200 * TOTAL_SAMPLES + 2000;

   logic                 clk_usb;
   logic                 reset;
   logic [7:0]           reg_address;
   logic [BYTECNT_W-1:0] reg_bytecnt;
   logic [7:0]           reg_datai;
   logic                 reg_write;
   logic                 reg_read;
   logic [7:0]           reg_datao;
   logic                 adc_valid;
   logic [SAMPLE_W-1:0]  adc_sample [NUM_CHAN];
   logic                 stream_valid;
   logic                 stream_ready;
   logic [SAMPLE_W-1:0]  stream_data;
   logic [CHAN_ID_W-1:0] stream_chan;

   integer seed   = 32'h8ec556e4;

   logic [SAMPLE_W-1:0]  got_data [$];   // words seen on the stream
   logic [CHAN_ID_W-1:0] got_chan [$];
   logic [SAMPLE_W-1:0]  exp_data [$];
   logic [CHAN_ID_W-1:0] exp_chan [$];

   scope_capture_top i_dut (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .reg_address_i  (reg_address),
      .reg_bytecnt_i  (reg_bytecnt),
      .reg_datai_i    (reg_datai),
      .reg_write_i    (reg_write),
      .reg_read_i     (reg_read),
      .reg_datao_o    (reg_datao),
      .adc_valid_i    (adc_valid),
      .adc_sample_i   (adc_sample),
      .stream_valid_o (stream_valid),
      .stream_ready_i (stream_ready),
      .stream_data_o  (stream_data),
      .stream_chan_o  (stream_chan)
   );

   initial begin
      clk_usb = 1'b0;
      forever #(CLK_PERIOD / 2) clk_usb = ~clk_usb;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      abort_run("watchdog expired before the tests finished");
   end

   always @(negedge clk_usb) begin
      if (!reset && stream_valid && stream_ready) begin   // taken at the next rising edge
         got_data.push_back(stream_data);
         got_chan.push_back(stream_chan);
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_mismatch(input string msg);
      abort_run($sformatf("FAIL at %0t ns: %s", $time, msg));
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp)
         report_mismatch($sformatf("%s read 0x%02h, expected 0x%02h", what, got, exp));
   endtask

   task automatic check_word(input logic [SAMPLE_W-1:0] got,
                             input logic [CHAN_ID_W-1:0] got_ch,
                             input logic [SAMPLE_W-1:0] exp,
                             input logic [CHAN_ID_W-1:0] exp_ch,
                             input string what);
      if (got !== exp || got_ch !== exp_ch)
         report_mismatch($sformatf("%s is %0d on channel %0d, expected %0d on channel %0d",
                                   what, got, got_ch, exp, exp_ch));
   endtask

   task automatic check_status_bit(input logic [7:0] status, input int pos, input logic exp,
                                   input string what);
      if (status[pos] !== exp)
         report_mismatch($sformatf("status %s is %b, expected %b", what, status[pos], exp));
   endtask

   task automatic write_byte(input logic [7:0] addr, input int lane, input logic [7:0] data);
      @(posedge clk_usb);
      reg_address <= addr;
      reg_bytecnt <= BYTECNT_W'(lane);
      reg_datai   <= data;
      reg_write   <= 1'b1;
      @(posedge clk_usb);
      reg_write   <= 1'b0;
   endtask

   // upper lanes first, the sample count saturates on every byte
   task automatic write_reg(input logic [7:0] addr, input int nbytes, input logic [63:0] value);
      for (int b = nbytes - 1; b >= 0; b--)
         write_byte(addr, b, value[b*8 +: 8]);
   endtask

   task automatic read_byte(input logic [7:0] addr, input int lane, output logic [7:0] data);
      @(posedge clk_usb);
      reg_address <= addr;
      reg_bytecnt <= BYTECNT_W'(lane);
      reg_read    <= 1'b1;
      @(negedge clk_usb);
      data = reg_datao;                  // combinational read path
      @(posedge clk_usb);
      reg_read    <= 1'b0;
   endtask

   task automatic expect_reg(input logic [7:0] addr, input int nbytes, input logic [63:0] exp,
                             input string name);
      logic [7:0] rd;
      for (int b = 0; b < nbytes; b++) begin
         read_byte(addr, b, rd);
         check_byte(rd, exp[b*8 +: 8], $sformatf("%s byte %0d", name, b));
      end
   endtask

   task automatic drive_sample(input logic [SAMPLE_W-1:0] s0, input logic [SAMPLE_W-1:0] s1);
      @(posedge clk_usb);
      adc_valid     <= 1'b1;
      adc_sample[0] <= s0;
      adc_sample[1] <= s1;
      @(posedge clk_usb);
      adc_valid     <= 1'b0;
   endtask

   task automatic next_random(output logic [SAMPLE_W-1:0] v);
      v = SAMPLE_W'($random(seed));
   endtask

   // gain has 4 fractional bits, result clamps at full scale
   function automatic logic [SAMPLE_W-1:0] scaled(input logic [SAMPLE_W-1:0] raw,
                                                  input int gain);
      int v;
      v = (int'(raw) * gain) >>> GAIN_SHIFT;
      return (v > int'(SAMPLE_MAX)) ? SAMPLE_W'(SAMPLE_MAX) : SAMPLE_W'(v);
   endfunction

   task automatic expect_words(input logic [SAMPLE_W-1:0] s0, input logic [SAMPLE_W-1:0] s1,
                               input int gain);
      exp_data.push_back(scaled(s0, gain));
      exp_chan.push_back(1'b0);
      exp_data.push_back(scaled(s1, gain));
      exp_chan.push_back(1'b1);
   endtask

   task automatic start_capture(input int gain, input int offset, input int decim,
                                input int count, input int chan, input int level,
                                input logic rising, input logic now);
      logic [7:0] set;
      set                  = '0;
      set[BIT_ARM]         = 1'b1;
      set[BIT_TRIG_RISING] = rising;
      write_reg(ADDR_SETTINGS, 1, 64'(1 << BIT_SOFT_RESET));   // capture path only
      write_reg(ADDR_GAIN, 1, 64'(gain));
      write_reg(ADDR_OFFSET, 4, 64'(offset));
      write_reg(ADDR_DECIMATE, 2, 64'(decim));
      write_reg(ADDR_SAMPLES, 4, 64'(count));
      write_reg(ADDR_TRIG_CHAN, 1, 64'(chan));
      write_reg(ADDR_TRIG_LEVEL, 2, 64'(level));
      write_reg(ADDR_SETTINGS, 1, 64'(set));
      repeat (2) @(posedge clk_usb);
      if (now) begin
         set[BIT_TRIG_NOW] = 1'b1;
         write_reg(ADDR_SETTINGS, 1, 64'(set));
      end
      repeat (2) @(posedge clk_usb);
      got_data.delete();
      got_chan.delete();
      exp_data.delete();
      exp_chan.delete();
   endtask

   task automatic wait_done(input string what);
      logic [7:0] st;
      bit         seen;
      seen = 1'b0;
      for (int polls = 0; polls < 100 && !seen; polls++) begin
         read_byte(ADDR_STATUS, 0, st);
         seen = st[BIT_DONE];
      end
      if (!seen)
         abort_run($sformatf("%s: the done status bit never came up", what));
   endtask

   task automatic compare_stream(input string name);
      if (got_data.size() != exp_data.size())
         report_mismatch($sformatf("%s gave %0d words, expected %0d", name,
                                   got_data.size(), exp_data.size()));
      foreach (exp_data[i])
         check_word(got_data[i], got_chan[i], exp_data[i], exp_chan[i],
                    $sformatf("%s word %0d", name, i));
   endtask

   task automatic reset_and_echo();
      logic [63:0] echo;
      expect_reg(ADDR_SETTINGS, 1, 64'(SETTINGS_RESET_VAL), "settings");
      expect_reg(ADDR_SAMPLES, 4, 64'(SAMPLES_RESET_VAL), "samples");
      expect_reg(ADDR_VERSION, 2, 64'(VERSION_CODE), "version");
      expect_reg(ADDR_MAX_SAMPLES, 4, 64'(MAX_SAMPLES), "max samples");
      expect_reg(ADDR_STATUS, 1, 64'd0, "status");
      echo = {32'($random(seed)), 32'($random(seed))};
      write_reg(ADDR_ECHO, 8, echo);
      expect_reg(ADDR_ECHO, 8, echo, "echo");
      write_reg(ADDR_SAMPLES, 4, 64'hffff_ffff);        // far above the limit
      expect_reg(ADDR_SAMPLES, 4, 64'(MAX_SAMPLES), "over-range samples");
   endtask

   task automatic decimated_capture();
      logic [SAMPLE_W-1:0] s0;
      logic [SAMPLE_W-1:0] s1;
      start_capture(16, 0, 2, 5, 0, 0, 1'b1, 1'b1);
      for (int i = 0; i < 15; i++) begin
         next_random(s0);
         next_random(s1);
         drive_sample(s0, s1);
         if (i % 3 == 0)                    // decimation 2 keeps every third
            expect_words(s0, s1, 16);
      end
      wait_done("decimated capture");
      compare_stream("decimated capture");
      expect_reg(ADDR_TRIG_DUR, 4, 64'd15, "trigger duration");
   endtask

   task automatic level_trigger(input logic rising);
      logic [SAMPLE_W-1:0] c0 [16];
      logic [SAMPLE_W-1:0] c1 [16];
      int                  k;
      for (int i = 0; i < 16; i++) begin
         next_random(c0[i]);
         next_random(c1[i]);
      end
      // a sure crossing at sample 6, an earlier random one may come first
      c1[5] = SAMPLE_W'(rising ? TRIG_LEVEL - 10 : TRIG_LEVEL + 10);
      c1[6] = SAMPLE_W'(rising ? TRIG_LEVEL + 10 : TRIG_LEVEL - 10);
      k = 1;                                 // sample 0 has no predecessor
      while (rising ? !(c1[k] >= TRIG_LEVEL && c1[k-1] < TRIG_LEVEL)
                    : !(c1[k] <= TRIG_LEVEL && c1[k-1] > TRIG_LEVEL))
         k++;                                // unity gain, scaled equals raw
      start_capture(16, 3, 0, 4, 1, TRIG_LEVEL, rising, 1'b0);
      for (int i = 0; i < 16; i++) begin
         drive_sample(c0[i], c1[i]);
         if (i >= k + 4 && i < k + 8)        // three skipped, then four taken
            expect_words(c0[i], c1[i], 16);
      end
      wait_done("level trigger");
      compare_stream(rising ? "rising trigger" : "falling trigger");
      expect_reg(ADDR_TRIG_DUR, 4, 64'd7, "level trigger duration");
   endtask

   task automatic clip_run(input logic no_clip, input logic [SAMPLE_W-1:0] s0 [2],
                           input logic [SAMPLE_W-1:0] s1 [2]);
      logic [7:0] st;
      write_reg(ADDR_NO_CLIP, 1, 64'(no_clip));
      start_capture(32, 0, 0, 2, 0, 0, 1'b1, 1'b1);
      for (int i = 0; i < 2; i++) begin
         drive_sample(s0[i], s1[i]);
         expect_words(s0[i], s1[i], 32);
      end
      wait_done("clip capture");
      compare_stream("clip capture");
      read_byte(ADDR_STATUS, 0, st);
      check_status_bit(st, BIT_CLIP0, !no_clip, "clip of channel 0");
      check_status_bit(st, BIT_CLIP0 + 1, 1'b0, "clip of channel 1");
   endtask

   task automatic clip_detection();
      logic [SAMPLE_W-1:0] s0 [2];
      logic [SAMPLE_W-1:0] s1 [2];
      logic [SAMPLE_W-1:0] r;
      for (int i = 0; i < 2; i++) begin
         next_random(r);
         s0[i] = SAMPLE_W'(512) + SAMPLE_W'(r[8:0]);       // saturates at gain 32
         next_random(r);
         s1[i] = SAMPLE_W'(r[8:0] % 9'd500) + 1'b1;        // below 512, off the rails
      end
      clip_run(1'b0, s0, s1);
      clip_run(1'b1, s0, s1);
      write_reg(ADDR_NO_CLIP, 1, 64'd0);
   endtask

   task automatic overflow_capture();
      logic [SAMPLE_W-1:0] s0;
      logic [SAMPLE_W-1:0] s1;
      logic [7:0]          st;
      start_capture(16, 0, 0, 2, 0, 0, 1'b1, 1'b1);
      @(posedge clk_usb);
      stream_ready <= 1'b0;
      for (int i = 0; i < 2; i++) begin
         next_random(s0);
         next_random(s1);
         drive_sample(s0, s1);
         if (i == 0)                         // second strobe finds the holds full
            expect_words(s0, s1, 16);
      end
      read_byte(ADDR_STATUS, 0, st);
      check_status_bit(st, BIT_OVERFLOW, 1'b1, "overflow while stalled");
      check_status_bit(st, BIT_DONE, 1'b0, "done while words held");
      @(posedge clk_usb);
      stream_ready <= 1'b1;
      wait_done("overflow capture");
      compare_stream("overflow capture");
      read_byte(ADDR_STATUS, 0, st);
      check_status_bit(st, BIT_OVERFLOW, 1'b1, "overflow after drain");
   endtask

   initial begin
      reset         = 1'b1;
      reg_address   = '0;
      reg_bytecnt   = '0;
      reg_datai     = '0;
      reg_write     = 1'b0;
      reg_read      = 1'b0;
      adc_valid     = 1'b0;
      adc_sample[0] = '0;
      adc_sample[1] = '0;
      stream_ready  = 1'b1;
      repeat (3) @(posedge clk_usb);
      reset <= 1'b0;

      reset_and_echo();
      decimated_capture();
      level_trigger(1'b1);
      level_trigger(1'b0);
      clip_detection();
      overflow_capture();
      repeat (4) @(posedge clk_usb);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- scope_capture.f
scope_pkg.sv
scope_cfg_if.sv
scope_regs.sv
capture_sequencer.sv
chan_condition.sv
stream_merge.sv
scope_capture_top.sv
tb_scope_capture.sv
